// ==== design/viterbi_pkg.sv ====
package viterbi_pkg;

   // trellis of the K=4 code
   localparam int NUM_STATES = 8;
   localparam int STATE_W    = 3;
   localparam int METRIC_W   = 8;

   // generator masks, applied to {input bit, state}
   localparam logic [3:0] G0 = 4'o17;
   localparam logic [3:0] G1 = 4'o15;

   typedef logic [1:0]            symbol_t;
   typedef logic [METRIC_W-1:0]   metric_t;
   typedef logic [1:0]            branch_metric_t;
   typedef logic [NUM_STATES-1:0] decision_t;
   typedef logic [STATE_W-1:0]    state_t;

   // traceback phases
   typedef enum logic [1:0] {
      TB_IDLE,
      TB_TRAIN,
      TB_DECODE
   } tb_state_e;

   // code pair sent for input bit b when the encoder sits in state s
   // code[1] comes from G0, code[0] from G1
   function automatic symbol_t code_pair(logic b, state_t s);
      logic [3:0] sr;
      sr = {b, s};
      return {^(sr & G0), ^(sr & G1)};
   endfunction

   // hamming distance between two code pairs
   function automatic branch_metric_t hamming(symbol_t a, symbol_t b);
      symbol_t diff;
      diff = a ^ b;
      return branch_metric_t'(diff[1]) + branch_metric_t'(diff[0]);
   endfunction

endpackage

// ==== design/traceback_if.sv ====
`timescale 1ns/1ns

interface traceback_if
   import viterbi_pkg::*;
();

   // survivor row, one cycle behind its read address
   decision_t row;

   // first row of a training pass
   logic      start;

   // high for every row of the decode pass
   logic      decode;

   // final row of the decode pass
   logic      last;

   modport mem (
      output row,
      output start,
      output decode,
      output last
   );

   modport tbu (
      input  row,
      input  start,
      input  decode,
      input  last
   );

endinterface

// ==== design/acs_array.sv ====
`timescale 1ns/1ns

module acs_array
   import viterbi_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      enable_i,
   input  symbol_t   code_i,
   output decision_t decision_o,
   output logic      decision_valid_o
);

   metric_t               pm_q [NUM_STATES];
   metric_t               pm_d [NUM_STATES];
   logic [METRIC_W:0]     sum0 [NUM_STATES];
   logic [METRIC_W:0]     sum1 [NUM_STATES];
   decision_t             dec_d;
   logic [NUM_STATES-1:0] top_bits;
   logic [NUM_STATES-1:0] sum_ovf;
   logic                  normalize;

   // every metric past half range
   always_comb begin
      for (int i = 0; i < NUM_STATES; i++) begin
         top_bits[i] = pm_q[i][METRIC_W-1];
      end
   end

   assign normalize = &top_bits;

   // one add-compare-select cell per next state
   always_comb begin
      state_t         ns;
      state_t         p0;
      state_t         p1;
      branch_metric_t bm0;
      branch_metric_t bm1;
      for (int i = 0; i < NUM_STATES; i++) begin
         ns  = state_t'(i);
         // both predecessors share the lower bits of ns
         p0  = {ns[1:0], 1'b0};
         p1  = {ns[1:0], 1'b1};
         bm0 = hamming(code_i, code_pair(ns[STATE_W-1], p0));
         bm1 = hamming(code_i, code_pair(ns[STATE_W-1], p1));
         sum0[i] = {1'b0, pm_q[p0]} + {{(METRIC_W-1){1'b0}}, bm0};
         sum1[i] = {1'b0, pm_q[p1]} + {{(METRIC_W-1){1'b0}}, bm1};
         // ties go to predecessor 0
         dec_d[i] = sum1[i] < sum0[i];
         if (dec_d[i]) begin
            pm_d[i]    = sum1[i][METRIC_W-1:0];
            sum_ovf[i] = sum1[i][METRIC_W];
         end else begin
            pm_d[i]    = sum0[i][METRIC_W-1:0];
            sum_ovf[i] = sum0[i][METRIC_W];
         end
         // subtract half the range from all metrics at once
         if (normalize) begin
            pm_d[i][METRIC_W-1] = 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pm_q             <= '{default: '0};
         decision_valid_o <= 1'b0;
      end else if (!enable_i) begin
         pm_q             <= '{default: '0};
         decision_valid_o <= 1'b0;
      end else begin
         pm_q             <= pm_d;
         decision_valid_o <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      decision_o <= dec_d;
   end

   // metric spread stays small, so the wide sum never carries out
   a_no_metric_overflow : assert property (
      @(posedge clk) disable iff (!rst)
      enable_i |-> (sum_ovf == '0)
   ) else $error("path metric overflow");

endmodule

// ==== design/survivor_memory.sv ====
`timescale 1ns/1ns

module survivor_memory
   import viterbi_pkg::*;
#(
   parameter int BLOCK_LEN = 32
)
(
   input  logic      clk,
   input  logic      rst,
   input  logic      enable_i,
   input  decision_t decision_i,
   input  logic      decision_valid_i,
   traceback_if.mem  tb0,
   traceback_if.mem  tb1
);

   localparam int STEP_W = $clog2(BLOCK_LEN);

   typedef logic [STEP_W-1:0] step_t;

   localparam step_t LAST_STEP = step_t'(BLOCK_LEN - 1);

   decision_t  mem [4][BLOCK_LEN];
   logic       step_go;
   step_t      wr_step;
   step_t      rd_addr;
   logic [1:0] wr_bank;
   logic [1:0] fill;
   logic [1:0] rd_bank [2];
   logic [1:0] rd_train;
   logic [1:0] rd_dec;
   decision_t  row_q [2];
   logic [1:0] start_q;
   logic [1:0] decode_q;
   logic [1:0] last_q;

   assign step_go = enable_i & decision_valid_i;
   // reads walk the step range backwards
   assign rd_addr = LAST_STEP - wr_step;

   // step and block counters
   // fill saturates once decoding can begin
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_step <= '0;
         wr_bank <= 2'd0;
         fill    <= 2'd0;
      end else if (!enable_i) begin
         wr_step <= '0;
         wr_bank <= 2'd0;
         fill    <= 2'd0;
      end else if (step_go) begin
         if (wr_step == LAST_STEP) begin
            wr_step <= '0;
            wr_bank <= wr_bank + 2'd1;
            if (fill != 2'd3) begin
               fill <= fill + 2'd1;
            end
         end else begin
            wr_step <= wr_step + step_t'(1);
         end
      end
   end

   // unit u trains in periods of its parity, decodes in the others
   always_comb begin
      for (int u = 0; u < 2; u++) begin
         rd_train[u] = step_go && (fill >= 2'd2) && (wr_bank[0] == u[0]);
         rd_dec[u]   = step_go && (fill == 2'd3) && (wr_bank[0] != u[0]);
         // previous block for training, three blocks back for decoding
         rd_bank[u]  = rd_train[u] ? wr_bank - 2'd1 : wr_bank + 2'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (step_go) begin
         mem[wr_bank][wr_step] <= decision_i;
      end
      for (int u = 0; u < 2; u++) begin
         row_q[u] <= mem[rd_bank[u]][rd_addr];
      end
   end

   // pass markers line up with the rows they tag
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         start_q  <= '0;
         decode_q <= '0;
         last_q   <= '0;
      end else if (!enable_i) begin
         start_q  <= '0;
         decode_q <= '0;
         last_q   <= '0;
      end else begin
         for (int u = 0; u < 2; u++) begin
            start_q[u]  <= rd_train[u] && (wr_step == '0);
            decode_q[u] <= rd_dec[u];
            last_q[u]   <= rd_dec[u] && (wr_step == LAST_STEP);
         end
      end
   end

   assign tb0.row    = row_q[0];
   assign tb0.start  = start_q[0];
   assign tb0.decode = decode_q[0];
   assign tb0.last   = last_q[0];
   assign tb1.row    = row_q[1];
   assign tb1.start  = start_q[1];
   assign tb1.decode = decode_q[1];
   assign tb1.last   = last_q[1];

   // a block once begun gets a new row every cycle
   a_rows_without_gaps : assert property (
      @(posedge clk) disable iff (!rst)
      (enable_i && (wr_step != '0)) |-> decision_valid_i
   ) else $error("decision row missing inside a survivor block");

endmodule

// ==== design/traceback_unit.sv ====
`timescale 1ns/1ns

module traceback_unit
   import viterbi_pkg::*;
(
   input  logic     clk,
   input  logic     rst,
   input  logic     enable_i,
   traceback_if.tbu job,
   output logic     bit_o,
   output logic     bit_valid_o
);

   tb_state_e state_q;
   state_t    trace_q;
   state_t    cur_state;
   logic      emit;

   // a training pass restarts the walk from state 0
   assign cur_state = job.start ? state_t'(0) : trace_q;

   // decode rows only count after a training pass
   assign emit = job.decode && (state_q != TB_IDLE);

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state_q     <= TB_IDLE;
         trace_q     <= '0;
         bit_valid_o <= 1'b0;
      end else if (!enable_i) begin
         state_q     <= TB_IDLE;
         trace_q     <= '0;
         bit_valid_o <= 1'b0;
      end else begin
         // step back to the predecessor picked by this row
         trace_q     <= {cur_state[1:0], job.row[cur_state]};
         bit_valid_o <= emit;
         if (job.start) begin
            state_q <= TB_TRAIN;
         end else begin
            case (state_q)
               TB_TRAIN: begin
                  if (job.decode) begin
                     state_q <= TB_DECODE;
                  end
               end
               TB_DECODE: begin
                  if (job.last) begin
                     state_q <= TB_IDLE;
                  end
               end
               default: begin
                  state_q <= TB_IDLE;
               end
            endcase
         end
      end
   end

   // decoded bit is the newest input held in the state
   always_ff @(posedge clk) begin
      bit_o <= cur_state[STATE_W-1];
   end

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ns

module reorder_buffer
#(
   parameter int BLOCK_LEN = 32
)
(
   input  logic clk,
   input  logic rst,
   input  logic enable_i,
   input  logic bit0_i,
   input  logic bit0_valid_i,
   input  logic bit1_i,
   input  logic bit1_valid_i,
   output logic d_out_o,
   output logic d_valid_o
);

   localparam int ADDR_W = $clog2(BLOCK_LEN);

   typedef logic [ADDR_W-1:0] addr_t;

   localparam addr_t LAST_ADDR = addr_t'(BLOCK_LEN - 1);

   logic [BLOCK_LEN-1:0] bank [2];
   logic                 in_bit;
   logic                 in_valid;
   logic                 blk_done;
   addr_t                wr_cnt;
   addr_t                wr_addr;
   addr_t                rd_cnt;
   logic                 wr_sel;
   logic                 rd_sel;
   logic                 rd_busy;

   // at most one unit is emitting
   assign in_bit   = bit0_valid_i ? bit0_i : bit1_i;
   assign in_valid = bit0_valid_i | bit1_valid_i;

   // bits arrive last step first
   assign wr_addr  = LAST_ADDR - wr_cnt;
   assign blk_done = in_valid && (wr_cnt == LAST_ADDR);

   always_ff @(posedge clk) begin
      if (in_valid) begin
         bank[wr_sel][wr_addr] <= in_bit;
      end
      d_out_o <= bank[rd_sel][rd_cnt];
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wr_cnt    <= '0;
         wr_sel    <= 1'b0;
         rd_cnt    <= '0;
         rd_sel    <= 1'b0;
         rd_busy   <= 1'b0;
         d_valid_o <= 1'b0;
      end else if (!enable_i) begin
         wr_cnt    <= '0;
         wr_sel    <= 1'b0;
         rd_cnt    <= '0;
         rd_sel    <= 1'b0;
         rd_busy   <= 1'b0;
         d_valid_o <= 1'b0;
      end else begin
         d_valid_o <= rd_busy;
         if (in_valid) begin
            wr_cnt <= blk_done ? '0 : wr_cnt + addr_t'(1);
         end
         // finished bank goes to the reader, writer takes the other one
         if (blk_done) begin
            wr_sel  <= ~wr_sel;
            rd_sel  <= wr_sel;
            rd_cnt  <= '0;
            rd_busy <= 1'b1;
         end else if (rd_busy) begin
            if (rd_cnt == LAST_ADDR) begin
               rd_cnt  <= '0;
               rd_busy <= 1'b0;
            end else begin
               rd_cnt <= rd_cnt + addr_t'(1);
            end
         end
      end
   end

   a_single_source : assert property (
      @(posedge clk) disable iff (!rst)
      !(bit0_valid_i && bit1_valid_i)
   ) else $error("both traceback units emitting at once");

endmodule

// ==== design/viterbi_decoder.sv ====
`timescale 1ns/1ns

module viterbi_decoder
   import viterbi_pkg::*;
#(
   parameter int BLOCK_LEN = 32
)
(
   input  logic    clk,
   input  logic    rst,
   input  logic    enable_i,
   input  symbol_t code_i,
   output logic    d_out_o,
   output logic    d_valid_o
);

   decision_t decision;
   logic      decision_valid;
   logic      tb0_bit;
   logic      tb0_bit_valid;
   logic      tb1_bit;
   logic      tb1_bit_valid;

   // one job channel per traceback unit
   traceback_if tb_job0 ();
   traceback_if tb_job1 ();

   acs_array acs0 (
      .clk              (clk),
      .rst              (rst),
      .enable_i         (enable_i),
      .code_i           (code_i),
      .decision_o       (decision),
      .decision_valid_o (decision_valid)
   );

   survivor_memory #(
      .BLOCK_LEN (BLOCK_LEN)
   ) smem0 (
      .clk              (clk),
      .rst              (rst),
      .enable_i         (enable_i),
      .decision_i       (decision),
      .decision_valid_i (decision_valid),
      .tb0              (tb_job0.mem),
      .tb1              (tb_job1.mem)
   );

   // even blocks
   traceback_unit tbu0 (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .job         (tb_job0.tbu),
      .bit_o       (tb0_bit),
      .bit_valid_o (tb0_bit_valid)
   );

   // odd blocks
   traceback_unit tbu1 (
      .clk         (clk),
      .rst         (rst),
      .enable_i    (enable_i),
      .job         (tb_job1.tbu),
      .bit_o       (tb1_bit),
      .bit_valid_o (tb1_bit_valid)
   );

   reorder_buffer #(
      .BLOCK_LEN (BLOCK_LEN)
   ) rob0 (
      .clk          (clk),
      .rst          (rst),
      .enable_i     (enable_i),
      .bit0_i       (tb0_bit),
      .bit0_valid_i (tb0_bit_valid),
      .bit1_i       (tb1_bit),
      .bit1_valid_i (tb1_bit_valid),
      .d_out_o      (d_out_o),
      .d_valid_o    (d_valid_o)
   );

endmodule

// ==== sim/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

   task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
      error_count++;
      $display("Fail at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
   endtask

   task automatic take_info_bit(output logic b);
      b    = lfsr[0];
      lfsr = lfsr_step(lfsr);
   endtask

   // enable low clears the decoder
   task automatic go_idle(int cycles);
      enable_i = 1'b0;
      code_i   = '0;
      repeat (cycles) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic start_stream();
      exp_q.delete();
      got_q.delete();
      enc_state  = '0;
      sent_count = 0;
   endtask

   // encode one bit, corrupt it by flip, clock it in
   task automatic send_symbol(logic b, logic [1:0] flip);
      symbol_t pair;
      pair      = encode_pair(b, enc_state);
      enc_state = {b, enc_state[2:1]};
      exp_q.push_back(b);
      enable_i  = 1'b1;
      code_i    = pair ^ flip;
      @(posedge clk);
      #1;
      // nothing comes out in the first four block periods
      if (sent_count < 4 * BLOCK_LEN) begin
         check_count++;
         if (d_valid_o !== 1'b0) begin
            report_mismatch("d_valid_o", 0, d_valid_o);
         end
      end
      sent_count++;
   endtask

   task automatic compare_bits(int num_bits);
      for (int i = 0; i < got_q.size() && i < num_bits; i++) begin
         check_count++;
         if (got_q[i] !== exp_q[i]) begin
            report_mismatch($sformatf("d_out_o[%0d]", i), exp_q[i], got_q[i]);
         end
      end
   endtask

   task automatic compare_output(int num_bits);
      check_count++;
      if (got_q.size() != num_bits) begin
         report_mismatch("decoded bit count", num_bits, got_q.size());
      end
      compare_bits(num_bits);
   endtask

   // data blocks, four zero padding blocks, then flush until done
   task automatic run_stream(int num_blocks, int err_period);
      logic       b;
      logic [1:0] flip;
      start_stream();
      for (int idx = 0; idx < (num_blocks + 4) * BLOCK_LEN; idx++) begin
         b    = 1'b0;
         flip = 2'b00;
         if (idx < num_blocks * BLOCK_LEN) begin
            take_info_bit(b);
         end
         // one bad code bit closes each error period and the flipped half alternates
         if (err_period > 0 && (idx % err_period) == err_period - 1) begin
            flip = ((idx / err_period) % 2 == 0) ? 2'b10 : 2'b01;
         end
         send_symbol(b, flip);
      end
      while (got_q.size() < num_blocks * BLOCK_LEN) begin
         send_symbol(1'b0, 2'b00);
      end
      compare_output(num_blocks * BLOCK_LEN);
      go_idle(2);
   endtask

   task automatic test_quiet_start();
      logic b;
      start_stream();
      repeat (4 * BLOCK_LEN) begin
         take_info_bit(b);
         send_symbol(b, 2'b00);
      end
      check_count++;
      if (got_q.size() != 0) begin
         report_mismatch("decoded bit count", 0, got_q.size());
      end
      go_idle(2);
   endtask

   task automatic test_clean_stream();
      run_stream(10, 0);
   endtask

   task automatic test_sparse_errors();
      run_stream(10, 12);
   endtask

   // dense errors push every metric past half range
   task automatic test_normalization();
      norm_count = 0;
      run_stream(40, 8);
      check_count++;
      if (norm_count == 0) begin
         error_count++;
         $display("metric normalization never happened during the 40 block run");
      end
   endtask

   task automatic test_enable_drop();
      logic b;
      start_stream();
      // stop inside the second output block
      repeat (5 * BLOCK_LEN + 10) begin
         take_info_bit(b);
         send_symbol(b, 2'b00);
      end
      check_count++;
      if (d_valid_o !== 1'b1) begin
         report_mismatch("d_valid_o", 1, d_valid_o);
      end
      check_count++;
      if (got_q.size() <= BLOCK_LEN) begin
         error_count++;
         $display("second output block had not started when enable dropped");
      end
      compare_bits(got_q.size());
      enable_i = 1'b0;
      code_i   = '0;
      repeat (3) begin
         @(posedge clk);
         #1;
         check_count++;
         if (d_valid_o !== 1'b0) begin
            report_mismatch("d_valid_o", 0, d_valid_o);
         end
      end
      run_stream(6, 0);
   endtask

`endif

// ==== sim/tb_viterbi_decoder.sv ====
`timescale 1ns/1ns

module tb_viterbi_decoder
   import viterbi_pkg::*;
();

   localparam int BLOCK_LEN = 32;
   // symbols fed by all tests together, padding included
   localparam int TOTAL_SYMBOLS  = (4 + 14 + 14 + 44 + 5 + 10) * BLOCK_LEN;
   localparam int TIMEOUT_CYCLES = TOTAL_SYMBOLS + 8 * BLOCK_LEN;
   localparam logic [31:0] LFSR_SEED = 32'hf0d2_b14f;
   localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

   logic        clk;
   logic        rst;
   logic        enable_i;
   symbol_t     code_i;
   logic        d_out_o;
   logic        d_valid_o;

   logic [31:0] lfsr;
   logic [2:0]  enc_state;
   logic        exp_q [$];
   logic        got_q [$];
   int          sent_count;
   int          check_count;
   int          error_count;
   int          norm_count;
   int          cycle_count;

   viterbi_decoder #(
      .BLOCK_LEN (BLOCK_LEN)
   ) dut0 (
      .clk       (clk),
      .rst       (rst),
      .enable_i  (enable_i),
      .code_i    (code_i),
      .d_out_o   (d_out_o),
      .d_valid_o (d_valid_o)
   );

   always #4 clk = ~clk;

   // galois form, shifts right
   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // reference encoder, bit b leaving state s
   function automatic symbol_t encode_pair(logic b, logic [2:0] s);
      logic g0_bit;
      logic g1_bit;
      // 17 octal taps the input and all three state bits
      g0_bit = b ^ s[2] ^ s[1] ^ s[0];
      // 15 octal skips the middle state bit
      g1_bit = b ^ s[2] ^ s[0];
      return {g0_bit, g1_bit};
   endfunction

   `include "tb_tasks.svh"

   // collector, outputs are settled by the falling edge
   always @(negedge clk) begin
      if (d_valid_o === 1'b1) begin
         got_q.push_back(d_out_o);
      end
      if (rst && enable_i && dut0.acs0.normalize) begin
         norm_count++;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, decoder output did not complete", cycle_count);
      $display("summary: %0d checks, %0d errors", check_count, error_count);
      $display("Checks failed");
      $finish;
   end

   initial begin
      clk         = 1'b0;
      rst         = 1'b0;
      enable_i    = 1'b0;
      code_i      = '0;
      lfsr        = LFSR_SEED;
      enc_state   = '0;
      sent_count  = 0;
      check_count = 0;
      error_count = 0;
      norm_count  = 0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b1;
      go_idle(2);
      test_quiet_start();
      test_clean_stream();
      test_sparse_errors();
      test_normalization();
      test_enable_drop();
      $display("summary: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== viterbi_decoder.f ====
+incdir+sim
design/viterbi_pkg.sv
design/traceback_if.sv
design/acs_array.sv
design/survivor_memory.sv
design/traceback_unit.sv
design/reorder_buffer.sv
design/viterbi_decoder.sv
sim/tb_viterbi_decoder.sv

// ==== Bender.yml ====
package:
  name: viterbi_decoder

sources:
  - files:
      - design/viterbi_pkg.sv
      - design/traceback_if.sv
      - design/acs_array.sv
      - design/survivor_memory.sv
      - design/traceback_unit.sv
      - design/reorder_buffer.sv
      - design/viterbi_decoder.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_viterbi_decoder.sv
